//--- axil_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "hm_cfg.svh"

module axil_regs import hm_pkg::*; (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic [`HM_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  word_t                 s_axi_wdata,
	input  logic [3:0]            s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [`HM_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output word_t                 s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready,
	input  word_t                 nonce,
	input  digest_t               digest,
	input  logic                  found,
	input  logic                  busy,
	output word_t                 header [7],
	output word_t                 target,
	output word_t                 nonce_start,
	output logic                  begin_hash,
	output logic                  quit_hash
);

	logic [`HM_ADDR_W-1:0] wr_addr;
	word_t wr_data;
	logic [3:0] wr_strb;
	logic wr_fire;
	word_t rd_word;

	// both halves captured and no response pending
	assign wr_fire = !s_axi_awready && !s_axi_wready && !s_axi_bvalid;

	assign s_axi_bresp = 2'b00;
	assign s_axi_rresp = 2'b00;

	// ########################################
	// write channels
	// ########################################

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			s_axi_awready <= 1'b1;
			s_axi_wready <= 1'b1;
			s_axi_bvalid <= 1'b0;
		end else begin
			if (s_axi_awvalid && s_axi_awready)
				s_axi_awready <= 1'b0;
			if (s_axi_wvalid && s_axi_wready)
				s_axi_wready <= 1'b0;
			if (wr_fire)
				s_axi_bvalid <= 1'b1;
			if (s_axi_bvalid && s_axi_bready) begin
				s_axi_bvalid <= 1'b0;
				s_axi_awready <= 1'b1;
				s_axi_wready <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_axi_awvalid && s_axi_awready)
			wr_addr <= s_axi_awaddr;
		if (s_axi_wvalid && s_axi_wready) begin
			wr_data <= s_axi_wdata;
			wr_strb <= s_axi_wstrb;
		end
	end

	// config registers and control pulses
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			target <= '0;
			nonce_start <= '0;
			for (int i = 0; i < 7; i++)
				header[i] <= '0;
			begin_hash <= 1'b0;
			quit_hash <= 1'b0;
		end else begin
			begin_hash <= 1'b0;
			quit_hash <= 1'b0;
			if (wr_fire && wr_strb == 4'hf) begin
				if (wr_addr == `HM_A_CTRL) begin
					begin_hash <= wr_data[0];
					quit_hash <= wr_data[1];
				end
				if (wr_addr == `HM_A_TARGET)
					target <= wr_data;
				if (wr_addr == `HM_A_NONCE)
					nonce_start <= wr_data;
				for (int i = 0; i < 7; i++)
					if (wr_addr == `HM_ADDR_W'(`HM_A_HDR + 4 * i))
						header[i] <= wr_data;
			end
		end
	end

	// ########################################
	// read channels
	// ########################################

	always_comb begin
		case (s_axi_araddr)
			`HM_A_STATUS: rd_word = {30'd0, found, busy};
			`HM_A_TARGET: rd_word = target;
			`HM_A_NONCE: rd_word = nonce;
			default: rd_word = '0;
		endcase
		for (int i = 0; i < 7; i++)
			if (s_axi_araddr == `HM_ADDR_W'(`HM_A_HDR + 4 * i))
				rd_word = header[i];
		for (int i = 0; i < 4; i++)
			if (s_axi_araddr == `HM_ADDR_W'(`HM_A_DIG + 4 * i))
				rd_word = digest[i];
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			s_axi_arready <= 1'b1;
			s_axi_rvalid <= 1'b0;
		end else if (s_axi_arvalid && s_axi_arready) begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid <= 1'b1;
		end else if (s_axi_rvalid && s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
			s_axi_arready <= 1'b1;
		end
	end

	// held until the master takes it
	always_ff @(posedge clk) begin
		if (s_axi_arvalid && s_axi_arready)
			s_axi_rdata <= rd_word;
	end

endmodule

`default_nettype wire

//--- hash_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "hm_cfg.svh"

module hash_datapath import hm_pkg::*; (
	input  logic      clk,
	input  logic      n_rst,
	input  logic      out_load,
	input  logic      increment,
	input  logic      load_nonce,
	input  hash_sel_t hash_select,
	input  word_t     header [7],
	input  word_t     target,
	input  word_t     nonce_start,
	input  digest_t   digest_out,
	output digest_t   chain_in,
	output word_t     msg [4],
	output word_t     nonce,
	output digest_t   digest,
	output logic      valid_hash_flag
);

	localparam digest_t IV = '{`HM_IV0, `HM_IV1, `HM_IV2, `HM_IV3};

	// result of pass 1, then of pass 2
	digest_t chain_q;

	// ########################################
	// per-pass start state and message
	// ########################################

	always_comb begin
		case (hash_select)
			PASS_HDR_HI: begin
				chain_in = chain_q;
				msg = '{header[4], header[5], header[6], nonce};
			end
			PASS_FINAL: begin
				chain_in = IV;
				msg = chain_q;
			end
			default: begin
				chain_in = IV;
				msg = '{header[0], header[1], header[2], header[3]};
			end
		endcase
	end

	// ########################################
	// chaining and result registers
	// ########################################

	always_ff @(posedge clk) begin
		if (out_load && hash_select != PASS_FINAL)
			chain_q <= digest_out;
		if (out_load && hash_select == PASS_FINAL)
			digest <= digest_out;
	end

	// nonce under test
	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			nonce <= '0;
		else if (load_nonce)
			nonce <= nonce_start;
		else if (increment)
			nonce <= nonce + 32'd1;
	end

	assign valid_hash_flag = digest[0] < target;

endmodule

`default_nettype wire

//--- hash_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hm_cfg.svh"

module hash_top import hm_pkg::*; (
	input  logic                  clk,
	input  logic                  n_rst,
	input  logic [`HM_ADDR_W-1:0] s_axi_awaddr,
	input  logic                  s_axi_awvalid,
	output logic                  s_axi_awready,
	input  word_t                 s_axi_wdata,
	input  logic [3:0]            s_axi_wstrb,
	input  logic                  s_axi_wvalid,
	output logic                  s_axi_wready,
	output logic [1:0]            s_axi_bresp,
	output logic                  s_axi_bvalid,
	input  logic                  s_axi_bready,
	input  logic [`HM_ADDR_W-1:0] s_axi_araddr,
	input  logic                  s_axi_arvalid,
	output logic                  s_axi_arready,
	output word_t                 s_axi_rdata,
	output logic [1:0]            s_axi_rresp,
	output logic                  s_axi_rvalid,
	input  logic                  s_axi_rready
);

	word_t header [7];
	word_t target;
	word_t nonce_start;
	word_t nonce;
	word_t msg [4];
	digest_t chain_in;
	digest_t digest_out;
	digest_t digest;
	hash_sel_t hash_select;
	logic begin_hash;
	logic quit_hash;
	logic init;
	logic cnt_up;
	logic out_load;
	logic increment;
	logic load_nonce;
	logic hash_done;
	logic busy;
	logic hash_rollover;
	logic valid_hash_flag;

	axil_regs u_regs (
		.clk, .n_rst,
		.s_axi_awaddr, .s_axi_awvalid, .s_axi_awready,
		.s_axi_wdata, .s_axi_wstrb, .s_axi_wvalid, .s_axi_wready,
		.s_axi_bresp, .s_axi_bvalid, .s_axi_bready,
		.s_axi_araddr, .s_axi_arvalid, .s_axi_arready,
		.s_axi_rdata, .s_axi_rresp, .s_axi_rvalid, .s_axi_rready,
		.nonce, .digest,
		// found is held for as long as the engine sits in hold
		.found(hash_done),
		.busy, .header, .target, .nonce_start, .begin_hash, .quit_hash
	);

	hm_controller u_ctrl (
		.clk, .n_rst, .begin_hash, .quit_hash, .hash_rollover, .valid_hash_flag,
		.init, .cnt_up, .out_load, .increment, .load_nonce, .hash_done, .busy,
		.hash_select
	);

	mix_core u_core (
		.clk, .n_rst, .init, .cnt_up, .chain_in, .msg, .digest_out, .hash_rollover
	);

	hash_datapath u_dp (
		.clk, .n_rst, .out_load, .increment, .load_nonce, .hash_select,
		.header, .target, .nonce_start, .digest_out,
		.chain_in, .msg, .nonce, .digest, .valid_hash_flag
	);

endmodule

`default_nettype wire

//--- hm_cfg.svh
`ifndef HM_CFG_SVH
`define HM_CFG_SVH

// ########################################
// compression rounds and constants
// ########################################

`define HM_ROUNDS 16

// starting chaining state, words A..D
`define HM_IV0 32'h6a09_e667
`define HM_IV1 32'hbb67_ae85
`define HM_IV2 32'h3c6e_f372
`define HM_IV3 32'ha54f_f53a

// scaled by the round index
`define HM_K 32'h9e37_79b9

// ########################################
// register map, byte addresses
// ########################################

`define HM_ADDR_W 8
`define HM_A_CTRL 8'h00
`define HM_A_STATUS 8'h04
`define HM_A_TARGET 8'h08
`define HM_A_NONCE 8'h0c
`define HM_A_HDR 8'h10
`define HM_A_DIG 8'h30

`endif

//--- hm_controller.sv
`timescale 1ns/1ps
`default_nettype none

module hm_controller import hm_pkg::*; (
	input  logic      clk,
	input  logic      n_rst,
	input  logic      begin_hash,
	input  logic      quit_hash,
	input  logic      hash_rollover,
	input  logic      valid_hash_flag,
	output logic      init,
	output logic      cnt_up,
	output logic      out_load,
	output logic      increment,
	output logic      load_nonce,
	output logic      hash_done,
	output logic      busy,
	output hash_sel_t hash_select
);

	typedef enum logic [3:0] {
		IDLE,
		INIT_LOAD1,
		CALC_HASH1,
		OUT_LOAD1,
		INIT_LOAD2,
		CALC_HASH2,
		OUT_LOAD2,
		INIT_LOAD3,
		CALC_HASH3,
		OUT_LOAD3,
		HASH_CHECK,
		INCREMENT,
		HOLD_HASH
	} state_t;

	state_t state;
	state_t next_state;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		init = 1'b0;
		cnt_up = 1'b0;
		out_load = 1'b0;
		increment = 1'b0;
		load_nonce = 1'b0;
		hash_done = 1'b0;
		hash_select = PASS_HDR_LO;

		case (state)
			IDLE: begin
				if (begin_hash) begin
					load_nonce = 1'b1;
					next_state = INIT_LOAD1;
				end
			end
			// pass 1, header words 0-3 from the IV
			INIT_LOAD1: begin
				init = 1'b1;
				next_state = CALC_HASH1;
			end
			CALC_HASH1: begin
				cnt_up = 1'b1;
				if (hash_rollover)
					next_state = OUT_LOAD1;
			end
			OUT_LOAD1: begin
				out_load = 1'b1;
				next_state = INIT_LOAD2;
			end
			// pass 2, chained from pass 1
			INIT_LOAD2: begin
				init = 1'b1;
				hash_select = PASS_HDR_HI;
				next_state = CALC_HASH2;
			end
			CALC_HASH2: begin
				cnt_up = 1'b1;
				hash_select = PASS_HDR_HI;
				if (hash_rollover)
					next_state = OUT_LOAD2;
			end
			OUT_LOAD2: begin
				out_load = 1'b1;
				hash_select = PASS_HDR_HI;
				next_state = INIT_LOAD3;
			end
			// pass 3 rehashes the pass 2 digest
			INIT_LOAD3: begin
				init = 1'b1;
				hash_select = PASS_FINAL;
				next_state = CALC_HASH3;
			end
			CALC_HASH3: begin
				cnt_up = 1'b1;
				hash_select = PASS_FINAL;
				if (hash_rollover)
					next_state = OUT_LOAD3;
			end
			OUT_LOAD3: begin
				out_load = 1'b1;
				hash_select = PASS_FINAL;
				next_state = HASH_CHECK;
			end
			HASH_CHECK: begin
				if (valid_hash_flag)
					next_state = HOLD_HASH;
				else
					next_state = INCREMENT;
			end
			INCREMENT: begin
				increment = 1'b1;
				next_state = INIT_LOAD1;
			end
			HOLD_HASH: begin
				hash_done = 1'b1;
				if (begin_hash) begin
					load_nonce = 1'b1;
					next_state = INIT_LOAD1;
				end
			end
			default: next_state = IDLE;
		endcase

		// quit wins over everything
		if (quit_hash) begin
			load_nonce = 1'b0;
			next_state = IDLE;
		end
	end

	assign busy = (state != IDLE) && (state != HOLD_HASH);

	// a pass ends only while the core is counting
	a_rollover_in_calc: assert property (@(posedge clk) disable iff (!n_rst)
		hash_rollover |-> cnt_up);

	// a held begin would restart straight out of hold
	a_begin_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		begin_hash |=> !begin_hash);

endmodule

`default_nettype wire

//--- hm_pkg.sv
`default_nettype none

package hm_pkg;

	// ########################################
	// shared datapath types
	// ########################################

	typedef logic [31:0] word_t;

	// compression state, element 0 is A
	typedef word_t digest_t [4];

	// which pass the core is working on
	typedef enum logic [1:0] {
		PASS_HDR_LO,
		PASS_HDR_HI,
		PASS_FINAL
	} hash_sel_t;

endpackage

`default_nettype wire

//--- mix_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "hm_cfg.svh"

module mix_core import hm_pkg::*; (
	input  logic    clk,
	input  logic    n_rst,
	input  logic    init,
	input  logic    cnt_up,
	input  digest_t chain_in,
	input  word_t   msg [4],
	output digest_t digest_out,
	output logic    hash_rollover
);

	localparam int CNT_W = $clog2(`HM_ROUNDS);

	digest_t state_q;
	digest_t start_q;
	logic [CNT_W-1:0] count;
	word_t m;
	word_t new_b;

	function automatic word_t rotl(input word_t x, input int unsigned n);
		return (x << n) | (x >> (32 - n));
	endfunction

	assign m = msg[count[1:0]];
	assign new_b = state_q[0] + (rotl(state_q[1], 7) ^ state_q[2]) + m
		+ (word_t'(count) * `HM_K);

	assign hash_rollover = cnt_up && (count == CNT_W'(`HM_ROUNDS - 1));

	// ########################################
	// round counter
	// ########################################

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst)
			count <= '0;
		else if (init || hash_rollover)
			count <= '0;
		else if (cnt_up)
			count <= count + 1'b1;
	end

	// ########################################
	// working state
	// ########################################

	always_ff @(posedge clk) begin
		if (init) begin
			start_q <= chain_in;
			state_q <= chain_in;
		end else if (cnt_up) begin
			state_q[0] <= state_q[3];
			state_q[1] <= new_b;
			state_q[2] <= state_q[1];
			state_q[3] <= state_q[2] ^ rotl(state_q[0], 13);
		end
	end

	// feed-forward of the start state
	always_comb begin
		for (int i = 0; i < 4; i++)
			digest_out[i] = state_q[i] + start_q[i];
	end

	// init during a run would drop a round
	a_init_cnt_excl: assert property (@(posedge clk) disable iff (!n_rst)
		!(init && cnt_up));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_hash_top \
	-Mdir obj_dir -o sim > build.log 2>&1 \
	&& ./obj_dir/sim > sim.log 2>&1 \
	|| { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "CHECKS FAILED" sim.log && { echo "simulation reported failures"; exit 1; } \
	|| echo "simulation passed"

//--- tb_hash_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "hm_cfg.svh"

module tb_hash_top import hm_pkg::*; ();

	typedef logic [3:0][31:0] quad_t;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int SEARCH_LIMIT = 200;

	logic clk;
	logic n_rst;
	logic [`HM_ADDR_W-1:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	word_t s_axi_wdata;
	logic [3:0] s_axi_wstrb;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [`HM_ADDR_W-1:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	word_t s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;

	word_t rng;
	word_t hdr [7];
	string test_name;
	int unsigned checks;
	int unsigned errors;
	int unsigned cycles;

	hash_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run length guard
	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout in %s: no result after %0d cycles", test_name, cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ########################################
	// reference model
	// ########################################

	function automatic word_t next_rand();
		rng = rng * 32'd1664525 + 32'd1013904223;
		return rng;
	endfunction

	function automatic word_t rotl32(input word_t x, input int n);
		return (x << n) | (x >> (32 - n));
	endfunction

	function automatic quad_t compress(input quad_t start, input quad_t m);
		quad_t s;
		quad_t n;
		s = start;
		for (int r = 0; r < `HM_ROUNDS; r++) begin
			n[0] = s[3];
			n[1] = s[0] + (rotl32(s[1], 7) ^ s[2]) + m[r % 4] + word_t'(r) * `HM_K;
			n[2] = s[1];
			n[3] = s[2] ^ rotl32(s[0], 13);
			s = n;
		end
		for (int i = 0; i < 4; i++)
			s[i] = s[i] + start[i];
		return s;
	endfunction

	// three passes for one nonce, element 0 is word A
	function automatic quad_t model_hash(input word_t nonce);
		quad_t iv;
		quad_t p1;
		quad_t p2;
		iv = {`HM_IV3, `HM_IV2, `HM_IV1, `HM_IV0};
		p1 = compress(iv, {hdr[3], hdr[2], hdr[1], hdr[0]});
		p2 = compress(p1, {nonce, hdr[6], hdr[5], hdr[4]});
		return compress(iv, p2);
	endfunction

	// attempt number of the first hit, 0 if none within the limit
	function automatic int unsigned attempts_needed(input word_t start, input word_t target,
			input int unsigned limit);
		quad_t d;
		for (int unsigned k = 0; k < limit; k++) begin
			d = model_hash(start + k);
			if (d[0] < target)
				return k + 1;
		end
		return 0;
	endfunction

	// ########################################
	// bus tasks and checks
	// ########################################

	task automatic check_value(input string what, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s %s: expected %h, got %h", test_name, what, exp, act);
		end
	endtask

	task automatic axil_write(input logic [`HM_ADDR_W-1:0] addr, input word_t data,
			input int bdelay);
		logic aw_pend;
		logic w_pend;
		logic aw_hs;
		logic w_hs;
		@(posedge clk);
		#1;
		s_axi_awaddr = addr;
		s_axi_awvalid = 1'b1;
		s_axi_wdata = data;
		s_axi_wstrb = 4'hf;
		s_axi_wvalid = 1'b1;
		aw_pend = 1'b1;
		w_pend = 1'b1;
		while (aw_pend || w_pend) begin
			@(negedge clk);
			aw_hs = s_axi_awvalid && s_axi_awready;
			w_hs = s_axi_wvalid && s_axi_wready;
			@(posedge clk);
			#1;
			if (aw_hs) begin
				s_axi_awvalid = 1'b0;
				aw_pend = 1'b0;
			end
			if (w_hs) begin
				s_axi_wvalid = 1'b0;
				w_pend = 1'b0;
			end
		end
		repeat (bdelay) @(posedge clk);
		#1;
		s_axi_bready = 1'b1;
		@(negedge clk);
		while (!s_axi_bvalid)
			@(negedge clk);
		check_value("bresp", 32'd0, word_t'(s_axi_bresp));
		@(posedge clk);
		#1;
		s_axi_bready = 1'b0;
		@(negedge clk);
		if (s_axi_bvalid) begin
			errors++;
			$display("%s: write response still valid after it was taken", test_name);
		end
	endtask

	task automatic axil_read(input logic [`HM_ADDR_W-1:0] addr, input int rdelay,
			output word_t data);
		word_t held;
		logic held_valid;
		held_valid = 1'b0;
		held = '0;
		@(posedge clk);
		#1;
		s_axi_araddr = addr;
		s_axi_arvalid = 1'b1;
		@(negedge clk);
		while (!s_axi_arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		s_axi_arvalid = 1'b0;
		// response must hold while the master stalls
		repeat (rdelay) begin
			@(negedge clk);
			if (s_axi_rvalid) begin
				if (held_valid && s_axi_rdata !== held) begin
					errors++;
					$display("%s: read data changed while RREADY was low", test_name);
				end
				held = s_axi_rdata;
				held_valid = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		s_axi_rready = 1'b1;
		@(negedge clk);
		while (!s_axi_rvalid)
			@(negedge clk);
		data = s_axi_rdata;
		check_value("rresp", 32'd0, word_t'(s_axi_rresp));
		if (held_valid)
			check_value("held rdata", held, data);
		@(posedge clk);
		#1;
		s_axi_rready = 1'b0;
		@(negedge clk);
		if (s_axi_rvalid) begin
			errors++;
			$display("%s: read response still valid after it was taken", test_name);
		end
	endtask

	// random header with a hit within the limit
	task automatic pick_header(input word_t start, input word_t target,
			input int unsigned limit, output int unsigned found_at);
		found_at = 0;
		while (found_at == 0) begin
			for (int i = 0; i < 7; i++)
				hdr[i] = next_rand();
			found_at = attempts_needed(start, target, limit);
		end
	endtask

	task automatic program_job(input word_t start, input word_t target);
		for (int i = 0; i < 7; i++)
			axil_write(`HM_ADDR_W'(`HM_A_HDR + 4 * i), hdr[i], 0);
		axil_write(`HM_A_TARGET, target, 0);
		axil_write(`HM_A_NONCE, start, 0);
	endtask

	task automatic wait_found(output word_t status);
		axil_read(`HM_A_STATUS, 0, status);
		while (!status[1])
			axil_read(`HM_A_STATUS, 0, status);
	endtask

	task automatic expect_result(input word_t nonce);
		quad_t d;
		word_t v;
		d = model_hash(nonce);
		axil_read(`HM_A_NONCE, 0, v);
		check_value("nonce", nonce, v);
		for (int i = 0; i < 4; i++) begin
			axil_read(`HM_ADDR_W'(`HM_A_DIG + 4 * i), 0, v);
			check_value($sformatf("digest[%0d]", i), d[i], v);
		end
	endtask

	task automatic run_job(input word_t start, input word_t target, input int unsigned found_at);
		word_t status;
		program_job(start, target);
		axil_write(`HM_A_CTRL, 32'h1, 0);
		wait_found(status);
		check_value("status", 32'h2, status);
		expect_result(start + found_at - 1);
	endtask

	// ########################################
	// directed tests
	// ########################################

	task automatic reset_and_registers();
		word_t v;
		test_name = "reset_and_registers";
		axil_read(`HM_A_STATUS, 0, v);
		check_value("status", 32'h0, v);
		for (int i = 0; i < 7; i++)
			hdr[i] = next_rand();
		program_job(32'h1234_5678, 32'h0bad_cafe);
		for (int i = 0; i < 7; i++) begin
			axil_read(`HM_ADDR_W'(`HM_A_HDR + 4 * i), 0, v);
			check_value($sformatf("header[%0d]", i), hdr[i], v);
		end
		axil_read(`HM_A_TARGET, 0, v);
		check_value("target", 32'h0bad_cafe, v);
		// current nonce, not loaded until a begin
		axil_read(`HM_A_NONCE, 0, v);
		check_value("nonce", 32'h0, v);
		axil_read(8'h2c, 0, v);
		check_value("unmapped 0x2c", 32'h0, v);
		axil_read(8'h40, 0, v);
		check_value("unmapped 0x40", 32'h0, v);
	endtask

	task automatic immediate_find();
		int unsigned found_at;
		test_name = "immediate_find";
		pick_header(32'h0000_0100, 32'hffff_ffff, 1, found_at);
		run_job(32'h0000_0100, 32'hffff_ffff, found_at);
	endtask

	task automatic nonce_search();
		int unsigned found_at;
		word_t start;
		test_name = "nonce_search";
		start = next_rand();
		pick_header(start, 32'h0400_0000, SEARCH_LIMIT, found_at);
		run_job(start, 32'h0400_0000, found_at);
	endtask

	task automatic restart_from_hold();
		int unsigned found_at;
		word_t start;
		word_t status;
		test_name = "restart_from_hold";
		axil_read(`HM_A_STATUS, 0, status);
		check_value("status in hold", 32'h2, status);
		start = next_rand();
		pick_header(start, 32'h8000_0000, 8, found_at);
		run_job(start, 32'h8000_0000, found_at);
	endtask

	task automatic quit_search();
		word_t status;
		test_name = "quit_search";
		program_job(32'h0, 32'h0);
		axil_write(`HM_A_CTRL, 32'h1, 0);
		repeat (40) @(posedge clk);
		axil_read(`HM_A_STATUS, 0, status);
		check_value("status while searching", 32'h1, status);
		axil_write(`HM_A_CTRL, 32'h2, 0);
		axil_read(`HM_A_STATUS, 0, status);
		check_value("status after quit", 32'h0, status);
		repeat (60) @(posedge clk);
		axil_read(`HM_A_STATUS, 0, status);
		check_value("status later", 32'h0, status);
	endtask

	task automatic bus_backpressure();
		word_t a;
		word_t b;
		word_t v;
		test_name = "bus_backpressure";
		a = next_rand();
		b = next_rand();
		axil_write(`HM_A_HDR, a, 5);
		axil_write(`HM_ADDR_W'(`HM_A_HDR + 4), b, 7);
		axil_write(`HM_A_TARGET, ~a, 3);
		axil_read(`HM_A_HDR, 6, v);
		check_value("header[0]", a, v);
		axil_read(`HM_ADDR_W'(`HM_A_HDR + 4), 4, v);
		check_value("header[1]", b, v);
		axil_read(`HM_A_TARGET, 8, v);
		check_value("target", ~a, v);
		axil_read(`HM_A_STATUS, 5, v);
		check_value("status", 32'h0, v);
	endtask

	initial begin
		rng = 32'hde5e_0d12;
		checks = 0;
		errors = 0;
		cycles = 0;
		test_name = "reset";
		n_rst = 1'b0;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wstrb = 4'h0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		n_rst = 1'b1;

		reset_and_registers();
		immediate_find();
		nonce_search();
		restart_from_hold();
		quit_search();
		bus_backpressure();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
hm_pkg.sv
hm_controller.sv
mix_core.sv
hash_datapath.sv
axil_regs.sv
hash_top.sv
tb_hash_top.sv
